// File: hdl/spindle_pkg.sv
package spindle_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // widths with a meaning
    ////////////////////////////////////////////////////////////////////////////

    // ieee-754 single precision word
    typedef logic [31:0] fp32_t;
    typedef logic [7:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;
    // cycle and tick counts
    typedef logic [31:0] count_t;

    ////////////////////////////////////////////////////////////////////////////
    // address map, byte offsets
    ////////////////////////////////////////////////////////////////////////////

    localparam apb_addr_t addr_ctrl        = 8'h00;
    localparam apb_addr_t addr_coef_ia     = 8'h04;
    localparam apb_addr_t addr_coef_ii     = 8'h08;
    localparam apb_addr_t addr_gain        = 8'h0C;
    localparam apb_addr_t addr_gamma_dyn   = 8'h10;
    localparam apb_addr_t addr_gamma_sta   = 8'h14;
    localparam apb_addr_t addr_half_cnt    = 8'h18;
    localparam apb_addr_t addr_bdamp_1     = 8'h1C;
    localparam apb_addr_t addr_bdamp_2     = 8'h20;
    localparam apb_addr_t addr_bdamp_chain = 8'h24;
    // read only
    localparam apb_addr_t addr_lce         = 8'h28;
    localparam apb_addr_t addr_tick_cnt    = 8'h2C;

    ////////////////////////////////////////////////////////////////////////////
    // reset defaults
    ////////////////////////////////////////////////////////////////////////////

    // 0.9 for both afferent coefficients
    localparam fp32_t     def_coef        = 32'h3F66_6666;
    localparam fp32_t     def_gain        = 32'h0000_0000;
    // 80.0 for both gamma drives
    localparam fp32_t     def_gamma       = 32'h42A0_0000;
    localparam count_t    def_half_cnt    = 32'd13;
    // bag1 ~0.2356, bag2 ~0.0362, chain ~0.0132
    localparam fp32_t     def_bdamp_1     = 32'h3E71_4120;
    localparam fp32_t     def_bdamp_2     = 32'h3D14_4674;
    localparam fp32_t     def_bdamp_chain = 32'h3C58_44D0;
    localparam apb_data_t def_ctrl        = 32'h0000_0000;

    // register selectors, sel_none for unmapped
    typedef enum logic [3:0] {
        sel_ctrl, sel_coef_ia, sel_coef_ii, sel_gain, sel_gamma_dyn, sel_gamma_sta,
        sel_half_cnt, sel_bdamp_1, sel_bdamp_2, sel_bdamp_chain, sel_lce, sel_tick_cnt,
        sel_none
    } reg_sel_t;

    // spindle model parameters, ctrl bit 0 is sim_hold
    typedef struct packed {
        apb_data_t ctrl;
        fp32_t     coef_ia;
        fp32_t     coef_ii;
        fp32_t     gain;
        fp32_t     gamma_dyn;
        fp32_t     gamma_sta;
        count_t    half_cnt;
        fp32_t     bdamp_1;
        fp32_t     bdamp_2;
        fp32_t     bdamp_chain;
    } spindle_params_t;

    localparam spindle_params_t params_default = '{
        ctrl:        def_ctrl,
        coef_ia:     def_coef,
        coef_ii:     def_coef,
        gain:        def_gain,
        gamma_dyn:   def_gamma,
        gamma_sta:   def_gamma,
        half_cnt:    def_half_cnt,
        bdamp_1:     def_bdamp_1,
        bdamp_2:     def_bdamp_2,
        bdamp_chain: def_bdamp_chain
    };

    // one register write, valid for a single cycle
    typedef struct packed {
        logic      valid;
        reg_sel_t  sel;
        apb_data_t data;
    } write_cmd_t;

endpackage

// File: hdl/apb_param_decode.sv
`timescale 1ns/100ps

module apb_param_decode
    import spindle_pkg::*;
(
    input  logic       psel,
    input  logic       penable,
    input  logic       pwrite,
    input  apb_addr_t  paddr,
    input  apb_data_t  pwdata,
    output logic       pready,
    output logic       pslverr,
    output write_cmd_t write_cmd,
    output reg_sel_t   rd_sel
);

    reg_sel_t sel;
    logic     read_only;
    logic     access;

    ////////////////////////////////////////////////////////////////////////////
    // address decode
    ////////////////////////////////////////////////////////////////////////////

    // full byte address compare, unaligned offsets fall to none
    always_comb
    begin
        sel       = sel_none;
        read_only = 1'b0;
        case (paddr)
            addr_ctrl:        sel = sel_ctrl;
            addr_coef_ia:     sel = sel_coef_ia;
            addr_coef_ii:     sel = sel_coef_ii;
            addr_gain:        sel = sel_gain;
            addr_gamma_dyn:   sel = sel_gamma_dyn;
            addr_gamma_sta:   sel = sel_gamma_sta;
            addr_half_cnt:    sel = sel_half_cnt;
            addr_bdamp_1:     sel = sel_bdamp_1;
            addr_bdamp_2:     sel = sel_bdamp_2;
            addr_bdamp_chain: sel = sel_bdamp_chain;
            addr_lce:
            begin
                sel       = sel_lce;
                read_only = 1'b1;
            end
            addr_tick_cnt:
            begin
                sel       = sel_tick_cnt;
                read_only = 1'b1;
            end
            default:          sel = sel_none;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // access phase response
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        // zero wait states, ready in every access phase
        access  = psel && penable;
        pready  = access;
        // unmapped, or write to a read-only word
        pslverr = access && ((sel == sel_none) || (pwrite && read_only));
        // one cycle pulse, erroring writes dropped
        write_cmd.valid = access && pwrite && (sel != sel_none) && !read_only;
        write_cmd.sel   = sel;
        write_cmd.data  = pwdata;
        // read select, none outside a read transfer
        rd_sel = (psel && !pwrite) ? sel : sel_none;
    end

endmodule

// File: hdl/param_bank.sv
`timescale 1ns/100ps

module param_bank
    import spindle_pkg::*;
(
    input  logic            ep50trig,
    input  logic            reset_global,
    input  write_cmd_t      write_cmd,
    output spindle_params_t params
);

    ////////////////////////////////////////////////////////////////////////////
    // parameter registers
    ////////////////////////////////////////////////////////////////////////////

    // one apb write replaces the per-register trigger bits
    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            // float defaults from the package
            params <= params_default;
        end
        else if (write_cmd.valid)
        begin
            case (write_cmd.sel)
                sel_ctrl:
                begin
                    // full word kept, only bit 0 acts
                    params.ctrl <= write_cmd.data;
                end
                sel_coef_ia:
                begin
                    params.coef_ia <= write_cmd.data;
                end
                sel_coef_ii:
                begin
                    params.coef_ii <= write_cmd.data;
                end
                sel_gain:
                begin
                    // zero gain selects the serial-link length
                    params.gain <= write_cmd.data;
                end
                sel_gamma_dyn:
                begin
                    params.gamma_dyn <= write_cmd.data;
                end
                sel_gamma_sta:
                begin
                    params.gamma_sta <= write_cmd.data;
                end
                sel_half_cnt:
                begin
                    // integer count, not a float
                    params.half_cnt <= write_cmd.data;
                end
                sel_bdamp_1:
                begin
                    params.bdamp_1 <= write_cmd.data;
                end
                sel_bdamp_2:
                begin
                    params.bdamp_2 <= write_cmd.data;
                end
                sel_bdamp_chain:
                begin
                    params.bdamp_chain <= write_cmd.data;
                end
                default:
                begin
                    // read-only and none never arrive valid
                    params <= params;
                end
            endcase
        end
    end

    // nothing moves between writes
    bank_stable_a : assert property (@(posedge ep50trig) disable iff (reset_global)
        !write_cmd.valid |=> $stable(params));

endmodule

// File: hdl/lce_sampler.sv
`timescale 1ns/100ps

module lce_sampler
    import spindle_pkg::*;
(
    input  logic            ep50trig,
    input  logic            reset_global,
    input  spindle_params_t params,
    input  fp32_t           spi_len,
    input  fp32_t           pipe_len,
    output fp32_t           lce,
    output logic            sim_tick,
    output count_t          tick_cnt
);

    count_t div_cnt;
    logic   sim_hold;
    fp32_t  len_src;

    // soft simulation reset, held while set
    assign sim_hold = params.ctrl[0];

    ////////////////////////////////////////////////////////////////////////////
    // tick divider
    ////////////////////////////////////////////////////////////////////////////

    // tick at or above half_cnt, period half_cnt+1
    assign sim_tick = !sim_hold && (div_cnt >= params.half_cnt);

    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
            div_cnt <= '0;
        else if (sim_hold || sim_tick)
            div_cnt <= '0;
        else
            div_cnt <= div_cnt + 32'd1;
    end

    ////////////////////////////////////////////////////////////////////////////
    // length sample and tick count
    ////////////////////////////////////////////////////////////////////////////

    // raw word compare, as on the board
    assign len_src = (params.gain == '0) ? spi_len : pipe_len;

    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            lce      <= '0;
            tick_cnt <= '0;
        end
        else if (sim_hold)
        begin
            lce      <= '0;
            tick_cnt <= '0;
        end
        else if (sim_tick)
        begin
            lce      <= len_src;
            tick_cnt <= tick_cnt + 32'd1;
        end
    end

    // counter wraps on a tick, so no back to back pulses
    tick_single_a : assert property (@(posedge ep50trig) disable iff (reset_global)
        sim_tick |=> (params.half_cnt == '0) || !sim_tick);

endmodule

// File: hdl/readback_mux.sv
`timescale 1ns/100ps

module readback_mux
    import spindle_pkg::*;
(
    input  reg_sel_t        rd_sel,
    input  spindle_params_t params,
    input  fp32_t           lce,
    input  count_t          tick_cnt,
    output apb_data_t       prdata
);

    ////////////////////////////////////////////////////////////////////////////
    // read data select
    ////////////////////////////////////////////////////////////////////////////

    // combinational, valid through the access phase
    always_comb
    begin
        case (rd_sel)
            sel_ctrl:        prdata = params.ctrl;
            sel_coef_ia:     prdata = params.coef_ia;
            sel_coef_ii:     prdata = params.coef_ii;
            sel_gain:        prdata = params.gain;
            sel_gamma_dyn:   prdata = params.gamma_dyn;
            sel_gamma_sta:   prdata = params.gamma_sta;
            sel_half_cnt:    prdata = params.half_cnt;
            sel_bdamp_1:     prdata = params.bdamp_1;
            sel_bdamp_2:     prdata = params.bdamp_2;
            sel_bdamp_chain: prdata = params.bdamp_chain;
            // sampler status
            sel_lce:         prdata = lce;
            sel_tick_cnt:    prdata = tick_cnt;
            // unmapped or no read
            default:         prdata = '0;
        endcase
    end

endmodule

// File: hdl/spindle_ctrl_top.sv
`timescale 1ns/100ps

module spindle_ctrl_top
    import spindle_pkg::*;
(
    input  logic            ep50trig,
    input  logic            reset_global,
    input  logic            psel,
    input  logic            penable,
    input  logic            pwrite,
    input  apb_addr_t       paddr,
    input  apb_data_t       pwdata,
    input  fp32_t           spi_len,
    input  fp32_t           pipe_len,
    output apb_data_t       prdata,
    output logic            pready,
    output logic            pslverr,
    output fp32_t           lce,
    output logic            sim_tick,
    output spindle_params_t spindle_params
);

    write_cmd_t write_cmd;
    reg_sel_t   rd_sel;
    count_t     tick_cnt;

    ////////////////////////////////////////////////////////////////////////////
    // decode, execute, result
    ////////////////////////////////////////////////////////////////////////////

    // apb slave
    apb_param_decode apb_param_decode_inst (
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .write_cmd (write_cmd),
        .rd_sel    (rd_sel)
    );

    // params leave the top for the spindle model
    param_bank param_bank_inst (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .write_cmd    (write_cmd),
        .params       (spindle_params)
    );

    lce_sampler lce_sampler_inst (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .params       (spindle_params),
        .spi_len      (spi_len),
        .pipe_len     (pipe_len),
        .lce          (lce),
        .sim_tick     (sim_tick),
        .tick_cnt     (tick_cnt)
    );

    readback_mux readback_mux_inst (
        .rd_sel   (rd_sel),
        .params   (spindle_params),
        .lce      (lce),
        .tick_cnt (tick_cnt),
        .prdata   (prdata)
    );

endmodule

// File: tb/tb_spindle_ctrl.sv
`timescale 1ns/100ps

module tb_spindle_ctrl
    import spindle_pkg::*;
();

    // longest tick period used below, half_cnt of 10
    localparam int max_period  = 11;
    // reset, defaults, write/read, errors, source, period, hold
    localparam int test_cycles = 16 + 36 + 60 + 42 + (9 + 2 * (max_period + 4))
                               + (3 + 5 * max_period + 4 * (max_period + 4))
                               + (9 + 3 * max_period + 10);
    localparam int timeout_cycles = 2 * test_cycles + 100;

    logic            ep50trig = 1'b0;
    logic            reset_global;
    logic            psel;
    logic            penable;
    logic            pwrite;
    apb_addr_t       paddr;
    apb_data_t       pwdata;
    fp32_t           spi_len;
    fp32_t           pipe_len;
    apb_data_t       prdata;
    logic            pready;
    logic            pslverr;
    fp32_t           lce;
    logic            sim_tick;
    spindle_params_t spindle_params;

    // expected register words, index is byte address / 4
    apb_data_t exp_regs [16];
    integer    seed = 69602;
    int        errors = 0;
    int        checks = 0;
    int        cycle_cnt = 0;

    always #5 ep50trig = ~ep50trig;

    spindle_ctrl_top spindle_ctrl_top_inst (
        .ep50trig       (ep50trig),
        .reset_global   (reset_global),
        .psel           (psel),
        .penable        (penable),
        .pwrite         (pwrite),
        .paddr          (paddr),
        .pwdata         (pwdata),
        .spi_len        (spi_len),
        .pipe_len       (pipe_len),
        .prdata         (prdata),
        .pready         (pready),
        .pslverr        (pslverr),
        .lce            (lce),
        .sim_tick       (sim_tick),
        .spindle_params (spindle_params)
    );

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic report_mismatch(input string name, input apb_data_t exp, input apb_data_t got);
        errors++;
        $display("Mismatch %s: expected 0x%08h, got 0x%08h at %0t", name, exp, got, $time);
    endtask

    // writable words 0x00..0x24, read-only 0x28 and 0x2C
    function automatic logic addr_writable(input apb_addr_t addr);
        return (addr[1:0] == 2'b00) && (addr <= 8'h24);
    endfunction

    function automatic logic addr_mapped(input apb_addr_t addr);
        return (addr[1:0] == 2'b00) && (addr <= 8'h2C);
    endfunction

    // ctrl is the top word of the struct
    function automatic apb_data_t param_word(input logic [3:0] idx);
        return apb_data_t'(spindle_params >> (32 * (9 - idx)));
    endfunction

    // called on a falling edge, returns on the falling edge after the transfer
    task automatic apb_transfer(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
                                output apb_data_t rdata, output logic err);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge ep50trig);
        penable = 1'b1;
        #1;
        // zero wait states expected, loop bounded by the timeout
        while (pready !== 1'b1)
        begin
            @(negedge ep50trig);
            #1;
        end
        rdata = prdata;
        err   = pslverr;
        @(negedge ep50trig);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic write_reg(input apb_addr_t addr, input apb_data_t data);
        apb_data_t rdata;
        logic      err;
        logic      exp_err;
        exp_err = !addr_writable(addr);
        apb_transfer(1'b1, addr, data, rdata, err);
        checks++;
        assert (err == exp_err)
            else report_mismatch("pslverr", {31'b0, exp_err}, {31'b0, err});
        if (!exp_err)
            exp_regs[addr[5:2]] = data;
    endtask

    task automatic read_reg(input apb_addr_t addr, output apb_data_t data);
        logic err;
        apb_transfer(1'b0, addr, '0, data, err);
        checks++;
        assert (err == !addr_mapped(addr))
            else report_mismatch("pslverr", {31'b0, !addr_mapped(addr)}, {31'b0, err});
    endtask

    task automatic read_expect(input apb_addr_t addr, input apb_data_t exp, input string name);
        apb_data_t data;
        read_reg(addr, data);
        checks++;
        assert (data == exp)
            else report_mismatch(name, exp, data);
    endtask

    // returns on the falling edge before the tick edge
    task automatic wait_tick();
        while (sim_tick !== 1'b1)
            @(negedge ep50trig);
    endtask

    task automatic read_all_params();
        apb_addr_t addr;
        addr = 8'h00;
        repeat (10)
        begin
            read_expect(addr, exp_regs[addr[5:2]], $sformatf("prdata@%02h", addr));
            addr = addr + 8'h04;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // protocol and sampler checks
    ////////////////////////////////////////////////////////////////////////////

    ready_a : assert property (@(posedge ep50trig) disable iff (reset_global)
        (psel && penable) |-> pready)
        else report_mismatch("pready", 32'h1, {31'b0, $sampled(pready)});

    // no tick while held
    hold_tick_a : assert property (@(posedge ep50trig) disable iff (reset_global)
        spindle_params.ctrl[0] |-> !sim_tick)
        else report_mismatch("sim_tick", 32'h0, 32'h1);

    hold_lce_a : assert property (@(posedge ep50trig) disable iff (reset_global)
        spindle_params.ctrl[0] |=> (lce == '0))
        else report_mismatch("lce", 32'h0, $sampled(lce));

    // lce only moves on a tick or a hold
    lce_stable_a : assert property (@(posedge ep50trig) disable iff (reset_global)
        (!spindle_params.ctrl[0] && !sim_tick) |=> $stable(lce))
        else report_mismatch("lce", $past(lce), $sampled(lce));

    tick_pulse_a : assert property (@(posedge ep50trig) disable iff (reset_global)
        (sim_tick && (spindle_params.half_cnt != '0)) |=> !sim_tick)
        else report_mismatch("sim_tick", 32'h0, 32'h1);

    // run limit
    always @(posedge ep50trig)
    begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= timeout_cycles)
        begin
            $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
            $display("checks %0d, errors %0d", checks, errors + 1);
            $display("Test failed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////

    initial
    begin
        apb_addr_t addr;
        apb_data_t data;
        apb_data_t prev;
        count_t    half_n;
        count_t    cycles;
        reset_global = 1'b1;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        paddr        = '0;
        pwdata       = '0;
        spi_len      = '0;
        pipe_len     = '0;
        // defaults from the register table
        for (int i = 0; i < 16; i++)
            exp_regs[i] = '0;
        exp_regs[1] = 32'h3F66_6666;
        exp_regs[2] = 32'h3F66_6666;
        exp_regs[4] = 32'h42A0_0000;
        exp_regs[5] = 32'h42A0_0000;
        exp_regs[6] = 32'd13;
        exp_regs[7] = 32'h3E71_4120;
        exp_regs[8] = 32'h3D14_4674;
        exp_regs[9] = 32'h3C58_44D0;
        repeat (16) @(negedge ep50trig);
        reset_global = 1'b0;

        // reset defaults, sampler status first, before the first tick
        read_expect(8'h28, 32'h0, "lce");
        read_expect(8'h2C, 32'h0, "tick_cnt");
        read_all_params();

        // write and read back, params port one cycle later
        addr = 8'h00;
        repeat (10)
        begin
            data = $random(seed);
            write_reg(addr, data);
            checks++;
            assert (param_word(addr[5:2]) == data)
                else report_mismatch("spindle_params", data, param_word(addr[5:2]));
            read_expect(addr, data, $sformatf("prdata@%02h", addr));
            addr = addr + 8'h04;
        end

        // erroring writes change nothing
        write_reg(8'h30, $random(seed));
        write_reg(8'h06, $random(seed));
        write_reg(8'h28, $random(seed));
        write_reg(8'h2C, $random(seed));
        read_all_params();

        // source select, spi on zero gain
        write_reg(8'h00, 32'h0);
        write_reg(8'h18, 32'd4);
        spi_len  = $random(seed);
        pipe_len = ~spi_len;
        write_reg(8'h0C, 32'h0);
        wait_tick();
        @(negedge ep50trig);
        read_expect(8'h28, spi_len, "lce");
        // pipe on nonzero gain, 1.0
        write_reg(8'h0C, 32'h3F80_0000);
        wait_tick();
        @(negedge ep50trig);
        read_expect(8'h28, pipe_len, "lce");

        // tick period, settle on one tick first
        half_n = 32'd3 + ($random(seed) & 32'h7);
        write_reg(8'h18, half_n);
        wait_tick();
        repeat (4)
        begin
            cycles = '0;
            do
            begin
                @(negedge ep50trig);
                cycles = cycles + 32'd1;
            end
            while (sim_tick !== 1'b1);
            checks++;
            assert (cycles == half_n + 32'd1)
                else report_mismatch("tick period", half_n + 32'd1, cycles);
        end
        // one count per pulse
        @(negedge ep50trig);
        read_reg(8'h2C, prev);
        repeat (3)
        begin
            wait_tick();
            @(negedge ep50trig);
            prev = prev + 32'd1;
            read_expect(8'h2C, prev, "tick_cnt");
        end

        // hold clears and freezes the sampler
        write_reg(8'h00, 32'h1);
        repeat (2 * max_period) @(negedge ep50trig);
        read_expect(8'h28, 32'h0, "lce");
        read_expect(8'h2C, 32'h0, "tick_cnt");
        write_reg(8'h00, 32'h0);
        wait_tick();
        @(negedge ep50trig);
        read_expect(8'h2C, 32'h1, "tick_cnt");

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// File: files.f
hdl/spindle_pkg.sv
hdl/apb_param_decode.sv
hdl/param_bank.sv
hdl/lce_sampler.sv
hdl/readback_mux.sv
hdl/spindle_ctrl_top.sv
tb/tb_spindle_ctrl.sv

// File: Makefile
# Verilator flow for the spindle controller testbench

VERILATOR ?= verilator
TOP       ?= tb_spindle_ctrl
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Test completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
